// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module connect_core_tb \
	-f tb.f -o connect_core_sim
out=$(./obj_dir/connect_core_sim 2>&1) || true
echo "$out"
if echo "$out" | grep -q "^NO ERRORS$"; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

// ==== source/board_store.sv ====
`timescale 1ns/1ps

`include "connect_consts.svh"

module board_store import connect_pkg::*; (
	input  logic              CLOCK_50,
	input  logic              rst_n,
	input  logic              clear_board,
	input  logic [`ROW_W-1:0] rd_row,
	output board_row_t        rd_data,
	input  logic              wr_en,
	input  move_t             wr_move,
	output board_t            board
);

	cell_t wr_cell;

	assign wr_cell = wr_move.player ? cell_yellow : cell_red;	// Colour of the mover

	//////////////////////////////
	// Cell registers
	//////////////////////////////

	always_ff @(posedge CLOCK_50) begin
		if (!rst_n || clear_board) begin
			board <= '0;	// Every cell back to empty
		end
		else if (wr_en) begin
			board[wr_move.row][wr_move.col] <= wr_cell;
		end
	end

	//////////////////////////////
	// Row read port
	//////////////////////////////

	// One cycle of latency, like a block RAM
	always_ff @(posedge CLOCK_50) begin
		rd_data <= board[rd_row];
	end

endmodule

// ==== source/connect_consts.svh ====
`ifndef CONNECT_CONSTS_SVH
`define CONNECT_CONSTS_SVH

//////////////////////////////
// Board geometry
//////////////////////////////

// Row 0 is the top row
`define BOARD_ROWS 6
`define BOARD_COLS 7

// Index widths
`define ROW_W 3
`define COL_W 3

//////////////////////////////
// Game rule
//////////////////////////////

`define WIN_LENGTH 4	// Pieces in a line to win

`endif

// ==== source/connect_core.sv ====
`timescale 1ns/1ps

`include "connect_consts.svh"

module connect_core import connect_pkg::*; (
	input  logic              CLOCK_50,
	input  logic              rst_n,
	input  logic [`COL_W-1:0] col,
	input  logic              turn,
	input  logic              drop_piece,
	input  logic              check_winner,
	input  logic              clear_board,
	output logic              drop_done,
	output logic              drop_ok,
	output move_t             placed,
	output logic              check_done,
	output logic              has_won,
	output logic              who_won
);

	logic [`ROW_W-1:0] rd_row;
	board_row_t        rd_data;
	logic              wr_en;
	move_t             wr_move;
	board_t            board;

	//////////////////////////////
	// Board, dropper and checker
	//////////////////////////////

	board_store board_store_inst (
		.CLOCK_50    (CLOCK_50),
		.rst_n       (rst_n),
		.clear_board (clear_board),
		.rd_row      (rd_row),
		.rd_data     (rd_data),
		.wr_en       (wr_en),
		.wr_move     (wr_move),
		.board       (board)
	);

	piece_dropper piece_dropper_inst (
		.CLOCK_50   (CLOCK_50),
		.rst_n      (rst_n),
		.drop_piece (drop_piece),
		.turn       (turn),
		.col        (col),
		.rd_row     (rd_row),
		.rd_data    (rd_data),
		.wr_en      (wr_en),
		.wr_move    (wr_move),
		.placed     (placed),
		.drop_done  (drop_done),
		.drop_ok    (drop_ok)
	);

	// Reads the whole board at once
	win_checker win_checker_inst (
		.CLOCK_50     (CLOCK_50),
		.rst_n        (rst_n),
		.check_winner (check_winner),
		.board        (board),
		.placed       (placed),
		.check_done   (check_done),
		.has_won      (has_won),
		.who_won      (who_won)
	);

endmodule

// ==== source/connect_pkg.sv ====
package connect_pkg;

	`include "connect_consts.svh"

	// Cell contents, red and yellow match the old display codes
	typedef enum logic [1:0] {
		cell_empty  = 2'd0,
		cell_red    = 2'd1,
		cell_yellow = 2'd2
	} cell_t;

	typedef cell_t [`BOARD_COLS-1:0] board_row_t;	// Index 0 is column 0
	typedef board_row_t [`BOARD_ROWS-1:0] board_t;	// Index 0 is the top row

	// One placed piece, player 0 is red
	typedef struct packed {
		logic [`ROW_W-1:0] row;
		logic [`COL_W-1:0] col;
		logic              player;
	} move_t;

	typedef enum logic [1:0] {
		drop_idle, drop_read, drop_test, drop_place
	} drop_state_t;

	typedef enum logic [1:0] {
		check_idle, check_count, check_report
	} check_state_t;

endpackage

// ==== source/piece_dropper.sv ====
`timescale 1ns/1ps

`include "connect_consts.svh"

module piece_dropper import connect_pkg::*; (
	input  logic              CLOCK_50,
	input  logic              rst_n,
	input  logic              drop_piece,
	input  logic              turn,
	input  logic [`COL_W-1:0] col,
	output logic [`ROW_W-1:0] rd_row,
	input  board_row_t        rd_data,
	output logic              wr_en,
	output move_t             wr_move,
	output move_t             placed,
	output logic              drop_done,
	output logic              drop_ok
);

	drop_state_t       state;
	logic [`COL_W-1:0] col_q;
	logic              turn_q;
	logic [`ROW_W-1:0] tgt_row;
	logic              ok_q;
	logic              hit;
	logic              last_row;

	assign hit      = rd_data[col_q] != cell_empty;	// Cell below the scan is taken
	assign last_row = rd_row == `ROW_W'(`BOARD_ROWS - 1);

	// Result is only shown in the place state
	assign drop_done = state == drop_place;
	assign drop_ok   = drop_done && ok_q;
	assign wr_en     = drop_ok;

	always_comb begin
		wr_move.row    = tgt_row;
		wr_move.col    = col_q;
		wr_move.player = turn_q;
	end

	//////////////////////////////
	// Scan FSM
	//////////////////////////////

	// rd_row doubles as the scan pointer, top to bottom
	always_ff @(posedge CLOCK_50) begin
		if (!rst_n) begin
			state  <= drop_idle;
			rd_row <= '0;
			ok_q   <= 1'b0;
			placed <= '0;
		end
		else begin
			case (state)
				drop_idle: begin
					if (drop_piece) begin
						rd_row <= '0;
						state  <= drop_read;
					end
				end
				drop_read: state <= drop_test;	// Address out, data next cycle
				drop_test: begin
					if (hit) begin
						ok_q  <= rd_row != '0;	// Top row taken means full column
						state <= drop_place;
					end
					else if (last_row) begin
						ok_q  <= 1'b1;	// Empty column, land on the bottom
						state <= drop_place;
					end
					else begin
						rd_row <= rd_row + 1'b1;
						state  <= drop_read;
					end
				end
				drop_place: begin
					if (drop_ok)
						placed <= wr_move;
					state <= drop_idle;
				end
				default: state <= drop_idle;
			endcase
		end
	end

	// Request data and landing row
	always_ff @(posedge CLOCK_50) begin
		if (state == drop_idle && drop_piece) begin
			col_q  <= col;
			turn_q <= turn;
		end
		if (state == drop_test)
			tgt_row <= (hit || !last_row) ? rd_row - 1'b1 : rd_row;
	end

endmodule

// ==== source/win_checker.sv ====
`timescale 1ns/1ps

`include "connect_consts.svh"

module win_checker import connect_pkg::*; (
	input  logic   CLOCK_50,
	input  logic   rst_n,
	input  logic   check_winner,
	input  board_t board,
	input  move_t  placed,
	output logic   check_done,
	output logic   has_won,
	output logic   who_won
);

	check_state_t state;
	move_t        move_q;
	logic [2:0]   run_d [7];
	logic [2:0]   run_q [7];
	logic [3:0]   line_len [4];
	logic         win_now;
	logic         won_q;

	// Matching pieces from the move outward, the move itself not counted
	function automatic logic [2:0] run_length(input board_t b, input move_t m,
		input int dr, input int dc);
		cell_t      want;
		int         r;
		int         c;
		logic       stop;
		logic [2:0] n;
		want = m.player ? cell_yellow : cell_red;
		stop = 1'b0;
		n    = '0;
		for (int i = 1; i < `WIN_LENGTH; i++) begin
			r = int'(m.row) + i * dr;
			c = int'(m.col) + i * dc;
			if (r < 0 || r >= `BOARD_ROWS || c < 0 || c >= `BOARD_COLS)
				stop = 1'b1;	// Off the board
			else if (!stop && b[r[`ROW_W-1:0]][c[`COL_W-1:0]] != want)
				stop = 1'b1;
			else if (!stop)
				n = n + 1'b1;
		end
		return n;
	endfunction

	//////////////////////////////
	// Direction counts
	//////////////////////////////

	always_comb begin
		run_d[0] = run_length(board, placed, 1, 0);	// Down
		run_d[1] = run_length(board, placed, 0, -1);	// Left
		run_d[2] = run_length(board, placed, 0, 1);	// Right
		run_d[3] = run_length(board, placed, -1, -1);	// Up left
		run_d[4] = run_length(board, placed, 1, 1);	// Down right
		run_d[5] = run_length(board, placed, 1, -1);	// Down left
		run_d[6] = run_length(board, placed, -1, 1);	// Up right
	end

	// Nothing sits above the last piece, so vertical is down only
	always_comb begin
		line_len[0] = 4'd1 + run_q[0];
		line_len[1] = 4'd1 + run_q[1] + run_q[2];
		line_len[2] = 4'd1 + run_q[3] + run_q[4];
		line_len[3] = 4'd1 + run_q[5] + run_q[6];
		win_now = 1'b0;
		for (int k = 0; k < 4; k++) begin
			if (line_len[k] >= `WIN_LENGTH)
				win_now = 1'b1;
		end
	end

	assign check_done = state == check_report;
	assign has_won    = check_done ? win_now : won_q;	// New result shows with the pulse
	assign who_won    = move_q.player;

	//////////////////////////////
	// Check FSM
	//////////////////////////////

	always_ff @(posedge CLOCK_50) begin
		if (!rst_n) begin
			state  <= check_idle;
			move_q <= '0;
			won_q  <= 1'b0;
		end
		else begin
			case (state)
				check_idle: if (check_winner) state <= check_count;
				check_count: begin
					move_q <= placed;
					state  <= check_report;
				end
				check_report: begin
					won_q <= win_now;	// Held until the next check
					state <= check_idle;
				end
				default: state <= check_idle;
			endcase
		end
	end

	always_ff @(posedge CLOCK_50) begin
		if (state == check_count)
			run_q <= run_d;
	end

endmodule

// ==== tb.f ====
+incdir+source
source/connect_pkg.sv
source/board_store.sv
source/piece_dropper.sv
source/win_checker.sv
source/connect_core.sv
verification/connect_core_sva.sv
verification/connect_core_tb.sv

// ==== verification/connect_core_sva.sv ====
`timescale 1ns/1ps

module connect_core_sva (
	input logic CLOCK_50,
	input logic rst_n,
	input logic check_winner,
	input logic drop_done,
	input logic drop_ok,
	input logic check_done
);

	logic chk_busy;	// A check is in flight
	logic chk_accept;

	assign chk_accept = check_winner && !chk_busy;

	always_ff @(posedge CLOCK_50) begin
		if (!rst_n)
			chk_busy <= 1'b0;
		else if (chk_accept)
			chk_busy <= 1'b1;
		else if (check_done)
			chk_busy <= 1'b0;
	end

	//////////////////////////////
	// Pulse rules
	//////////////////////////////

	drop_pulse: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
		drop_done |=> !drop_done) else $error("drop_done longer than one cycle");

	check_pulse: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
		check_done |=> !check_done) else $error("check_done longer than one cycle");

	// Two cycles from request to result
	check_latency: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
		chk_accept |=> !check_done ##1 check_done) else $error("check_done latency wrong");

	ok_with_done: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
		drop_ok |-> drop_done) else $error("drop_ok outside drop_done");

endmodule

bind connect_core connect_core_sva connect_core_sva_inst (
	.CLOCK_50     (CLOCK_50),
	.rst_n        (rst_n),
	.check_winner (check_winner),
	.drop_done    (drop_done),
	.drop_ok      (drop_ok),
	.check_done   (check_done)
);

// ==== verification/connect_core_tb.sv ====
`timescale 1ns/1ps

`include "connect_consts.svh"

module connect_core_tb import connect_pkg::*; ();

	logic              CLOCK_50;
	logic              rst_n;
	logic [`COL_W-1:0] col;
	logic              turn;
	logic              drop_piece;
	logic              check_winner;
	logic              clear_board;
	logic              drop_done;
	logic              drop_ok;
	move_t             placed;
	logic              check_done;
	logic              has_won;
	logic              who_won;

	cell_t  model [`BOARD_ROWS][`BOARD_COLS];	// Expected board
	move_t  last_move;	// Expected placed
	integer seed;

	connect_core connect_core_inst (
		.CLOCK_50     (CLOCK_50),
		.rst_n        (rst_n),
		.col          (col),
		.turn         (turn),
		.drop_piece   (drop_piece),
		.check_winner (check_winner),
		.clear_board  (clear_board),
		.drop_done    (drop_done),
		.drop_ok      (drop_ok),
		.placed       (placed),
		.check_done   (check_done),
		.has_won      (has_won),
		.who_won      (who_won)
	);

	always #20 CLOCK_50 = ~CLOCK_50;

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("ERRORS FOUND");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
			stop_on_error($sformatf("Fail %s got %h expected %h", name, got, expected));
	endtask

	//////////////////////////////
	// Board model
	//////////////////////////////

	function automatic void clear_model();
		foreach (model[r, c])
			model[r][c] = cell_empty;
	endfunction

	// Gravity puts the piece in the lowest free row, -1 when full
	function automatic int lowest_empty(input int c);
		for (int r = `BOARD_ROWS - 1; r >= 0; r--) begin
			if (model[r][c] == cell_empty)
				return r;
		end
		return -1;
	endfunction

	function automatic int count_run(input int r, input int c, input int dr, input int dc,
		input cell_t who);
		int n;
		n = 0;
		r = r + dr;
		c = c + dc;
		while (r >= 0 && r < `BOARD_ROWS && c >= 0 && c < `BOARD_COLS) begin
			if (model[r][c] != who)
				break;
			n++;
			r = r + dr;
			c = c + dc;
		end
		return n;
	endfunction

	function automatic logic model_wins();
		cell_t who;
		int    r;
		int    c;
		int    len;
		int    dr [4];
		int    dc [4];
		logic  won;
		who = last_move.player ? cell_yellow : cell_red;
		r   = int'(last_move.row);
		c   = int'(last_move.col);
		dr  = '{0, 1, 1, 1};	// Row, column, two diagonals
		dc  = '{1, 0, 1, -1};
		won = 1'b0;
		for (int k = 0; k < 4; k++) begin
			len = 1 + count_run(r, c, dr[k], dc[k], who) + count_run(r, c, -dr[k], -dc[k], who);
			if (len >= `WIN_LENGTH)
				won = 1'b1;
		end
		return won;
	endfunction

	//////////////////////////////
	// Bus actions
	//////////////////////////////

	task automatic pulse_clear();
		@(negedge CLOCK_50);
		clear_board = 1'b1;
		@(negedge CLOCK_50);
		clear_board = 1'b0;
		clear_model();
	endtask

	task automatic drop_and_check(input int c, input logic player);
		int row;
		int cycles;
		row = lowest_empty(c);
		@(negedge CLOCK_50);
		col        = c[`COL_W-1:0];
		turn       = player;
		drop_piece = 1'b1;
		@(negedge CLOCK_50);
		drop_piece = 1'b0;
		cycles     = 0;
		while (!drop_done) begin
			if (cycles == 40)
				stop_on_error("Timeout while waiting for drop_done");
			@(negedge CLOCK_50);
			cycles++;
		end
		check_value("drop_ok", drop_ok, row >= 0);
		@(negedge CLOCK_50);	// placed moves one edge after drop_done
		if (row >= 0) begin
			model[row][c]    = player ? cell_yellow : cell_red;
			last_move.row    = row[`ROW_W-1:0];
			last_move.col    = c[`COL_W-1:0];
			last_move.player = player;
		end
		check_value("placed", placed, last_move);
	endtask

	task automatic issue_check(input logic exp_won, input logic exp_who);
		int cycles;
		@(negedge CLOCK_50);
		check_winner = 1'b1;
		@(negedge CLOCK_50);
		check_winner = 1'b0;
		cycles       = 0;
		while (!check_done) begin
			if (cycles == 10)
				stop_on_error("Timeout while waiting for check_done");
			@(negedge CLOCK_50);
			cycles++;
		end
		check_value("has_won", has_won, exp_won);
		check_value("who_won", who_won, exp_who);
		@(negedge CLOCK_50);
		check_value("has_won", has_won, exp_won);	// Held after the pulse
		check_value("who_won", who_won, exp_who);
	endtask

	//////////////////////////////
	// Directed tests
	//////////////////////////////

	task automatic check_reset_state();
		check_value("drop_done", drop_done, 0);
		check_value("drop_ok", drop_ok, 0);
		check_value("check_done", check_done, 0);
		check_value("has_won", has_won, 0);
		check_value("who_won", who_won, 0);
		check_value("placed", placed, 0);
	endtask

	task automatic stack_one_column();
		for (int i = 0; i < `BOARD_ROWS; i++) begin
			drop_and_check(3, i[0]);	// Alternate red and yellow
			check_value("placed.row", placed.row, `BOARD_ROWS - 1 - i);
			check_value("placed.col", placed.col, 3);
			check_value("placed.player", placed.player, i[0]);
		end
	endtask

	// Last good move was yellow on top of column 3
	task automatic reject_full_column();
		drop_and_check(3, 1'b0);
		check_value("placed.row", placed.row, 0);
		check_value("placed.col", placed.col, 3);
		check_value("placed.player", placed.player, 1);
	endtask

	task automatic find_straight_wins();
		pulse_clear();
		for (int i = 0; i < 3; i++) begin
			drop_and_check(0, 1'b0);
		end
		issue_check(1'b0, 1'b0);	// Three red only
		drop_and_check(0, 1'b0);
		issue_check(1'b1, 1'b0);
		pulse_clear();
		for (int c = 1; c < 4; c++) begin
			drop_and_check(c, 1'b1);
		end
		issue_check(1'b0, 1'b1);
		drop_and_check(4, 1'b1);	// Bottom row of four yellow
		issue_check(1'b1, 1'b1);
	endtask

	task automatic find_diagonal_win();
		int   cols [10];
		logic who [10];
		cols = '{0, 1, 1, 2, 2, 2, 3, 3, 3, 3};
		who  = '{1, 0, 1, 0, 0, 1, 0, 0, 0, 1};	// Yellow tops each step
		pulse_clear();
		for (int i = 0; i < 9; i++) begin
			drop_and_check(cols[i], who[i]);
		end
		issue_check(1'b0, 1'b0);
		drop_and_check(cols[9], who[9]);
		issue_check(1'b1, 1'b1);
	endtask

	task automatic clear_and_refill();
		pulse_clear();
		for (int c = 0; c < `BOARD_COLS; c++) begin
			drop_and_check(c, c[0]);
			check_value("placed.row", placed.row, `BOARD_ROWS - 1);
		end
	endtask

	task automatic play_random_game();
		int   c;
		int   r;
		logic won;
		pulse_clear();
		for (int i = 0; i < 60; i++) begin
			c = $unsigned($random(seed)) % `BOARD_COLS;
			r = $random(seed);
			drop_and_check(c, r[0]);
			won = model_wins();
			issue_check(won, last_move.player);
			if (won)
				pulse_clear();
		end
	endtask

	initial begin
		CLOCK_50     = 1'b0;
		rst_n        = 1'b0;
		col          = '0;
		turn         = 1'b0;
		drop_piece   = 1'b0;
		check_winner = 1'b0;
		clear_board  = 1'b0;
		seed         = 68;
		last_move    = '0;
		clear_model();
		repeat (5) @(negedge CLOCK_50);
		rst_n = 1'b1;
		check_reset_state();
		stack_one_column();
		reject_full_column();
		find_straight_wins();
		find_diagonal_win();
		clear_and_refill();
		play_random_game();
		$display("NO ERRORS");
		$finish;
	end

endmodule
